//--- common/rq_pkg.sv
// shared definitions for the rename issue queue
// widths, instruction field positions, types, state enum, latencies
`default_nettype none

package rq_pkg;

  //////////////////////////////////////////////////
  // register file geometry
  //////////////////////////////////////////////////
  localparam int NUM_LREG        = 16;
  localparam int NUM_PREG        = 64;
  localparam int LREG_W          = 4;
  localparam int PREG_W          = 6;
  // ready bit on top of the physical number
  localparam int MAP_ENT_W       = PREG_W + 1;
  localparam int OP_W            = 8;

  // queue and free list sizes
  localparam int QUEUE_DEPTH     = 4;
  localparam int FIRST_FREE_PREG = 16;
  localparam int FREE_DEPTH      = 48;

  // cycles from the issue pulse to the done pulse
  localparam int EXEC_LAT        = 3;

  //////////////////////////////////////////////////
  // instruction layout, msb first
  // lsrc1 vld | lsrc1 | lsrc2 vld | lsrc2 | ldst vld | ldst | op
  //////////////////////////////////////////////////
  localparam int BIT_LSRC1_VLD   = 22;
  localparam int LSRC1_LSB       = 18;
  localparam int BIT_LSRC2_VLD   = 17;
  localparam int LSRC2_LSB       = 13;
  localparam int BIT_LDST_VLD    = 12;
  localparam int LDST_LSB        = 8;
  localparam int OP_LSB          = 0;

  typedef logic [LREG_W-1:0]             lreg_t;
  typedef logic [PREG_W-1:0]             preg_t;
  typedef logic [MAP_ENT_W-1:0]          map_ent_t;
  // logical register 0 in the low bits
  typedef logic [NUM_LREG*MAP_ENT_W-1:0] map_t;
  typedef logic [22:0]                   inst_t;
  typedef logic [1:0]                    line_idx_t;

  // dispatch handshake states
  typedef enum logic {
    IDLE,
    ACK
  } disp_state_t;

endpackage

`default_nettype wire

//--- filelist.f
common/rq_pkg.sv
rename_queue/rq_line.sv
rename_queue/rq_store.sv
rename_queue/rq_ctrl.sv
hdl/preg_free_list.sv
hdl/exec_timer.sv
hdl/rename_issue_top.sv
tb/tb_clock.sv
tb/rename_issue_tb.sv

//--- hdl/exec_timer.sv
// fixed latency model of the execution unit
`timescale 1ns/1ps
`default_nettype none

module exec_timer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  rq_pkg::line_idx_t start_line_i,
  output logic              busy_o,
  output logic              done_o,
  output rq_pkg::line_idx_t done_line_o
);

  localparam int CNT_W = $clog2(rq_pkg::EXEC_LAT + 1);

  logic [CNT_W-1:0]  cnt;
  rq_pkg::line_idx_t line_q;

  // count down from EXEC_LAT, done in the last busy cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt <= '0;
    end
    else if (start_i)
    begin
      cnt <= CNT_W'(rq_pkg::EXEC_LAT);
    end
    else if (cnt != '0)
    begin
      cnt <= cnt - 1'b1;
    end
  end

  // line index of the op in flight
  always_ff @(posedge clk)
  begin
    if (start_i)
    begin
      line_q <= start_line_i;
    end
  end

  assign busy_o      = (cnt != '0);
  assign done_o      = (cnt == CNT_W'(1));
  assign done_line_o = line_q;

  a_no_start_busy : assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> !busy_o);

endmodule

`default_nettype wire

//--- hdl/preg_free_list.sv
// free physical register FIFO
// starts full with the registers above the architectural set
`timescale 1ns/1ps
`default_nettype none

module preg_free_list (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          pop_i,
  input  logic          push_i,
  input  rq_pkg::preg_t push_preg_i,
  output rq_pkg::preg_t head_preg_o,
  output logic          empty_o
);

  localparam int PTR_W = $clog2(rq_pkg::FREE_DEPTH);
  localparam int CNT_W = $clog2(rq_pkg::FREE_DEPTH + 1);

  rq_pkg::preg_t    mem [rq_pkg::FREE_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;

  // pointer wrap at depth, which is not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    ptr_inc = (p == PTR_W'(rq_pkg::FREE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // storage, preloaded at reset
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < rq_pkg::FREE_DEPTH; i++)
      begin
        mem[i] <= rq_pkg::preg_t'(rq_pkg::FIRST_FREE_PREG + i);
      end
    end
    else if (push_i)
    begin
      mem[wr_ptr] <= push_preg_i;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= CNT_W'(rq_pkg::FREE_DEPTH);
    end
    else
    begin
      if (pop_i)
      begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (push_i)
      begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (push_i && !pop_i)
      begin
        count <= count + 1'b1;
      end
      else if (pop_i && !push_i)
      begin
        count <= count - 1'b1;
      end
    end
  end

  assign head_preg_o = mem[rd_ptr];
  assign empty_o     = (count == '0);

  // at most NUM_PREG - NUM_LREG registers are ever free
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    (push_i && !pop_i) |-> (count < CNT_W'(rq_pkg::NUM_PREG - rq_pkg::NUM_LREG)));

endmodule

`default_nettype wire

//--- hdl/rename_issue_top.sv
// rename issue queue top
// store, map chain of four lines, control, free list, exec timer
`timescale 1ns/1ps
`default_nettype none

module rename_issue_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   disp_req_i,
  input  rq_pkg::inst_t          disp_inst_i,
  output logic                   disp_ack_o,
  output logic                   iss_valid_o,
  output logic [rq_pkg::OP_W-1:0] iss_op_o,
  output rq_pkg::preg_t          iss_psrc1_o,
  output rq_pkg::preg_t          iss_psrc2_o,
  output rq_pkg::preg_t          iss_pdst_o,
  output logic                   retire_valid_o,
  output rq_pkg::lreg_t          ret_ldst_o,
  output rq_pkg::preg_t          ret_pdst_o,
  output logic                   ret_free_vld_o,
  output rq_pkg::preg_t          ret_free_preg_o
);

  localparam int QD = rq_pkg::QUEUE_DEPTH;

  rq_pkg::inst_t [QD-1:0]    inst;
  rq_pkg::preg_t [QD-1:0]    pdst;
  logic [QD-1:0]             vld, issued, done_flag, src_rdy, dst_rdy, free_vld;
  rq_pkg::map_t [QD-1:0]     cur_map;
  rq_pkg::map_ent_t [QD-1:0] psrc1, psrc2;
  rq_pkg::preg_t [QD-1:0]    free_preg;
  rq_pkg::map_t              arch_map;
  logic                      disp_we, pop, free_empty, issue, retire;
  logic                      timer_busy, timer_done;
  rq_pkg::line_idx_t         disp_line, issue_line, done_line;
  rq_pkg::preg_t             head_preg;

  rq_store rq_store_inst (
    .clk(clk), .rst_n(rst_n),
    .disp_we_i(disp_we), .disp_line_i(disp_line),
    .disp_inst_i(disp_inst_i), .disp_pdst_i(head_preg),
    .issue_i(issue), .issue_line_i(issue_line),
    .done_i(timer_done), .done_line_i(done_line),
    .retire_i(retire), .commit_map_i(cur_map[0]),
    .inst_o(inst), .pdst_o(pdst), .vld_o(vld),
    .issued_o(issued), .done_o(done_flag), .arch_map_o(arch_map)
  );

  //////////////////////////////////////////////////
  // map chain, line 0 starts from the architectural map
  //////////////////////////////////////////////////
  for (genvar k = 0; k < QD; k++)
  begin : g_line
    rq_line rq_line_inst (
      .clk(clk), .rst_n(rst_n),
      .inst_i(inst[k]), .pdst_i(pdst[k]), .vld_i(vld[k]),
      .ld_i(disp_we && (disp_line == rq_pkg::line_idx_t'(k))),
      .done_i(timer_done && (done_line == rq_pkg::line_idx_t'(k))),
      .shift_i(retire),
      .upper_rdy_i((k == QD-1) ? 1'b1 : dst_rdy[(k+1) % QD]),
      .prv_map_i((k == 0) ? arch_map : cur_map[(k+QD-1) % QD]),
      .cur_map_o(cur_map[k]), .psrc1_o(psrc1[k]), .psrc2_o(psrc2[k]),
      .src_rdy_o(src_rdy[k]), .free_vld_o(free_vld[k]),
      .free_preg_o(free_preg[k]), .dst_rdy_o(dst_rdy[k])
    );
  end

  rq_ctrl rq_ctrl_inst (
    .clk(clk), .rst_n(rst_n),
    .disp_req_i(disp_req_i), .free_empty_i(free_empty),
    .vld_i(vld), .issued_i(issued), .done_i(done_flag), .src_rdy_i(src_rdy),
    .timer_busy_i(timer_busy),
    .disp_ack_o(disp_ack_o), .disp_we_o(disp_we), .disp_line_o(disp_line),
    .pop_o(pop), .issue_o(issue), .issue_line_o(issue_line), .retire_o(retire)
  );

  // old register of the head's ldst returns on retire
  preg_free_list preg_free_list_inst (
    .clk(clk), .rst_n(rst_n),
    .pop_i(pop), .push_i(retire && free_vld[0]), .push_preg_i(free_preg[0]),
    .head_preg_o(head_preg), .empty_o(free_empty)
  );

  exec_timer exec_timer_inst (
    .clk(clk), .rst_n(rst_n),
    .start_i(issue), .start_line_i(issue_line),
    .busy_o(timer_busy), .done_o(timer_done), .done_line_o(done_line)
  );

  // issue port, muxed from the selected line
  assign iss_valid_o = issue;
  assign iss_op_o    = inst[issue_line][rq_pkg::OP_LSB +: rq_pkg::OP_W];
  assign iss_psrc1_o = psrc1[issue_line][rq_pkg::PREG_W-1:0];
  assign iss_psrc2_o = psrc2[issue_line][rq_pkg::PREG_W-1:0];
  assign iss_pdst_o  = pdst[issue_line];

  // retire port, always the head line
  assign retire_valid_o  = retire;
  assign ret_ldst_o      = inst[0][rq_pkg::LDST_LSB +: rq_pkg::LREG_W];
  assign ret_pdst_o      = pdst[0];
  assign ret_free_vld_o  = free_vld[0];
  assign ret_free_preg_o = free_preg[0];

endmodule

`default_nettype wire

//--- rename_queue/rq_ctrl.sv
// issue queue control
// dispatch handshake FSM, oldest-ready issue select, in-order retire
`timescale 1ns/1ps
`default_nettype none

module rq_ctrl (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           disp_req_i,
  input  logic                           free_empty_i,
  input  logic [rq_pkg::QUEUE_DEPTH-1:0] vld_i,
  input  logic [rq_pkg::QUEUE_DEPTH-1:0] issued_i,
  input  logic [rq_pkg::QUEUE_DEPTH-1:0] done_i,
  input  logic [rq_pkg::QUEUE_DEPTH-1:0] src_rdy_i,
  input  logic                           timer_busy_i,
  output logic                           disp_ack_o,
  output logic                           disp_we_o,
  output rq_pkg::line_idx_t              disp_line_o,
  output logic                           pop_o,
  output logic                           issue_o,
  output rq_pkg::line_idx_t              issue_line_o,
  output logic                           retire_o
);

  localparam int OCC_W = $clog2(rq_pkg::QUEUE_DEPTH + 1);

  rq_pkg::disp_state_t            state_q, state_d;
  logic [OCC_W-1:0]               occ;
  logic                           has_slot;
  logic [rq_pkg::QUEUE_DEPTH-1:0] cand;
  logic                           cand_any;

  //////////////////////////////////////////////////
  // retire
  //////////////////////////////////////////////////
  // head done and nothing in flight, since a shift would
  // invalidate the line index held by the timer
  assign retire_o = vld_i[0] & done_i[0] & ~timer_busy_i;

  //////////////////////////////////////////////////
  // dispatch
  //////////////////////////////////////////////////
  // lines stay packed toward line 0, so occupancy is the next free slot
  always_comb
  begin
    occ = '0;
    for (int k = 0; k < rq_pkg::QUEUE_DEPTH; k++)
    begin
      occ = occ + OCC_W'(vld_i[k]);
    end
  end

  // a retiring head makes room in the same cycle
  assign has_slot    = (occ < OCC_W'(rq_pkg::QUEUE_DEPTH)) | retire_o;
  assign disp_line_o = rq_pkg::line_idx_t'(occ - OCC_W'(retire_o));

  // one write per handshake, only from IDLE
  assign disp_we_o = (state_q == rq_pkg::IDLE) & disp_req_i & has_slot & ~free_empty_i;
  assign pop_o     = disp_we_o;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      rq_pkg::IDLE:
      begin
        if (disp_we_o)
        begin
          state_d = rq_pkg::ACK;
        end
      end
      rq_pkg::ACK:
      begin
        // hold ack until the requester lets go
        if (!disp_req_i)
        begin
          state_d = rq_pkg::IDLE;
        end
      end
      default:
      begin
        state_d = rq_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= rq_pkg::IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  assign disp_ack_o = (state_q == rq_pkg::ACK);

  //////////////////////////////////////////////////
  // issue select
  //////////////////////////////////////////////////
  assign cand = vld_i & ~issued_i & src_rdy_i;

  // walk from the youngest down so the oldest candidate sticks
  always_comb
  begin
    cand_any     = 1'b0;
    issue_line_o = '0;
    for (int k = rq_pkg::QUEUE_DEPTH-1; k >= 0; k--)
    begin
      if (cand[k])
      begin
        cand_any     = 1'b1;
        issue_line_o = rq_pkg::line_idx_t'(k);
      end
    end
  end

  // single unit, and retire gets the cycle first
  assign issue_o = cand_any & ~timer_busy_i & ~retire_o;

  // slot index above relies on valid lines packed toward line 0
  a_lines_packed : assert property (@(posedge clk) disable iff (!rst_n)
    (vld_i & (vld_i + 1'b1)) == '0);

endmodule

`default_nettype wire

//--- rename_queue/rq_line.sv
// one issue queue line
// source lookup in the incoming map, destination ready flop,
// outgoing map with this line's destination, register to free
`timescale 1ns/1ps
`default_nettype none

module rq_line (
  input  logic             clk,
  input  logic             rst_n,
  input  rq_pkg::inst_t    inst_i,
  input  rq_pkg::preg_t    pdst_i,
  input  logic             vld_i,
  input  logic             ld_i,
  input  logic             done_i,
  input  logic             shift_i,
  input  logic             upper_rdy_i,
  input  rq_pkg::map_t     prv_map_i,
  output rq_pkg::map_t     cur_map_o,
  output rq_pkg::map_ent_t psrc1_o,
  output rq_pkg::map_ent_t psrc2_o,
  output logic             src_rdy_o,
  output logic             free_vld_o,
  output rq_pkg::preg_t    free_preg_o,
  output logic             dst_rdy_o
);

  rq_pkg::lreg_t    lsrc1;
  rq_pkg::lreg_t    lsrc2;
  rq_pkg::lreg_t    ldst;
  logic             has_dst;
  logic             dst_rdy_q;
  rq_pkg::map_ent_t old_ent;

  // field extraction
  assign lsrc1   = inst_i[rq_pkg::LSRC1_LSB +: rq_pkg::LREG_W];
  assign lsrc2   = inst_i[rq_pkg::LSRC2_LSB +: rq_pkg::LREG_W];
  assign ldst    = inst_i[rq_pkg::LDST_LSB +: rq_pkg::LREG_W];
  assign has_dst = vld_i & inst_i[rq_pkg::BIT_LDST_VLD];

  //////////////////////////////////////////////////
  // source renaming
  //////////////////////////////////////////////////
  // an absent source or an empty line reads as ready p0
  assign psrc1_o = (vld_i && inst_i[rq_pkg::BIT_LSRC1_VLD]) ?
                   prv_map_i[rq_pkg::MAP_ENT_W*lsrc1 +: rq_pkg::MAP_ENT_W] :
                   {1'b1, rq_pkg::preg_t'(0)};
  assign psrc2_o = (vld_i && inst_i[rq_pkg::BIT_LSRC2_VLD]) ?
                   prv_map_i[rq_pkg::MAP_ENT_W*lsrc2 +: rq_pkg::MAP_ENT_W] :
                   {1'b1, rq_pkg::preg_t'(0)};

  // both ready bits set
  assign src_rdy_o = psrc1_o[rq_pkg::PREG_W] & psrc2_o[rq_pkg::PREG_W];

  //////////////////////////////////////////////////
  // destination ready flop
  //////////////////////////////////////////////////
  // load clears, completion sets, retire pulls the value from the line above
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dst_rdy_q <= 1'b0;
    end
    else if (ld_i)
    begin
      dst_rdy_q <= 1'b0;
    end
    else if (done_i)
    begin
      dst_rdy_q <= 1'b1;
    end
    else if (shift_i)
    begin
      dst_rdy_q <= upper_rdy_i;
    end
  end

  // no destination means nothing for younger lines to wait on
  assign dst_rdy_o = dst_rdy_q | ~inst_i[rq_pkg::BIT_LDST_VLD];

  //////////////////////////////////////////////////
  // outgoing map and freed register
  //////////////////////////////////////////////////
  assign old_ent = prv_map_i[rq_pkg::MAP_ENT_W*ldst +: rq_pkg::MAP_ENT_W];

  always_comb
  begin
    cur_map_o = prv_map_i;
    // overwrite only our ldst entry
    if (has_dst)
    begin
      cur_map_o[rq_pkg::MAP_ENT_W*ldst +: rq_pkg::MAP_ENT_W] = {dst_rdy_q, pdst_i};
    end
  end

  // previous owner of ldst goes back to the free list at retire
  assign free_vld_o  = has_dst;
  assign free_preg_o = old_ent[rq_pkg::PREG_W-1:0];

  // dispatch and completion target different lines
  a_ld_done_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(ld_i && done_i));

endmodule

`default_nettype wire

//--- rename_queue/rq_store.sv
// issue queue line storage and architectural map register
// lines shift down on retire, dispatch fills the top free slot
`timescale 1ns/1ps
`default_nettype none

module rq_store (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    disp_we_i,
  input  rq_pkg::line_idx_t                       disp_line_i,
  input  rq_pkg::inst_t                           disp_inst_i,
  input  rq_pkg::preg_t                           disp_pdst_i,
  input  logic                                    issue_i,
  input  rq_pkg::line_idx_t                       issue_line_i,
  input  logic                                    done_i,
  input  rq_pkg::line_idx_t                       done_line_i,
  input  logic                                    retire_i,
  input  rq_pkg::map_t                            commit_map_i,
  output rq_pkg::inst_t [rq_pkg::QUEUE_DEPTH-1:0] inst_o,
  output rq_pkg::preg_t [rq_pkg::QUEUE_DEPTH-1:0] pdst_o,
  output logic [rq_pkg::QUEUE_DEPTH-1:0]          vld_o,
  output logic [rq_pkg::QUEUE_DEPTH-1:0]          issued_o,
  output logic [rq_pkg::QUEUE_DEPTH-1:0]          done_o,
  output rq_pkg::map_t                            arch_map_o
);

  rq_pkg::inst_t [rq_pkg::QUEUE_DEPTH-1:0] inst_q;
  rq_pkg::preg_t [rq_pkg::QUEUE_DEPTH-1:0] pdst_q;
  logic [rq_pkg::QUEUE_DEPTH-1:0]          vld_q, vld_d;
  logic [rq_pkg::QUEUE_DEPTH-1:0]          issued_q, issued_d;
  logic [rq_pkg::QUEUE_DEPTH-1:0]          done_q, done_d;
  rq_pkg::map_t                            arch_q;

  //////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (retire_i)
    begin
      for (int k = 0; k < rq_pkg::QUEUE_DEPTH-1; k++)
      begin
        inst_q[k] <= inst_q[k+1];
        pdst_q[k] <= pdst_q[k+1];
      end
    end
    // dispatch index is already post-shift, so this write wins
    if (disp_we_i)
    begin
      inst_q[disp_line_i] <= disp_inst_i;
      pdst_q[disp_line_i] <= disp_pdst_i;
    end
  end

  //////////////////////////////////////////////////
  // per-line status
  //////////////////////////////////////////////////
  always_comb
  begin
    vld_d    = vld_q;
    issued_d = issued_q;
    done_d   = done_q;
    // issue and done use pre-shift indices
    if (issue_i)
    begin
      issued_d[issue_line_i] = 1'b1;
    end
    if (done_i)
    begin
      done_d[done_line_i] = 1'b1;
    end
    if (retire_i)
    begin
      vld_d    = vld_d >> 1;
      issued_d = issued_d >> 1;
      done_d   = done_d >> 1;
    end
    if (disp_we_i)
    begin
      vld_d[disp_line_i]    = 1'b1;
      issued_d[disp_line_i] = 1'b0;
      done_d[disp_line_i]   = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      vld_q    <= '0;
      issued_q <= '0;
      done_q   <= '0;
    end
    else
    begin
      vld_q    <= vld_d;
      issued_q <= issued_d;
      done_q   <= done_d;
    end
  end

  //////////////////////////////////////////////////
  // architectural map
  //////////////////////////////////////////////////
  // reset to identity, every entry ready
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < rq_pkg::NUM_LREG; i++)
      begin
        arch_q[rq_pkg::MAP_ENT_W*i +: rq_pkg::MAP_ENT_W] <= {1'b1, rq_pkg::preg_t'(i)};
      end
    end
    else if (retire_i)
    begin
      arch_q <= commit_map_i;
    end
  end

  assign inst_o     = inst_q;
  assign pdst_o     = pdst_q;
  assign vld_o      = vld_q;
  assign issued_o   = issued_q;
  assign done_o     = done_q;
  assign arch_map_o = arch_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rename issue queue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module rename_issue_tb -f filelist.f

# a fatal stop exits non-zero, the search below decides the result
sim_out=$(./obj_dir/Vrename_issue_tb 2>&1) || true
echo "$sim_out"

if grep -qxF "Finished with no errors" <<< "$sim_out"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

//--- tb/rename_issue_tb.sv
// testbench for the rename issue queue
// stimulus table with a rename reference model, four-phase dispatch driver,
// issue and retire monitor, cycle limit
`timescale 1ns/1ps
`default_nettype none

module rename_issue_tb;

  localparam int NUM_ROWS     = 60;
  localparam int RESET_CYCLES = 10;
  // generous per-row budget plus reset
  localparam int CYCLE_LIMIT  = NUM_ROWS * 20 + RESET_CYCLES;

  logic                    clk;
  logic                    rst_n;
  logic                    disp_req;
  rq_pkg::inst_t           disp_inst;
  logic                    disp_ack;
  logic                    iss_valid;
  logic [rq_pkg::OP_W-1:0] iss_op;
  rq_pkg::preg_t           iss_psrc1;
  rq_pkg::preg_t           iss_psrc2;
  rq_pkg::preg_t           iss_pdst;
  logic                    retire_valid;
  rq_pkg::lreg_t           ret_ldst;
  rq_pkg::preg_t           ret_pdst;
  logic                    ret_free_vld;
  rq_pkg::preg_t           ret_free_preg;

  // stimulus table
  rq_pkg::inst_t row_inst    [NUM_ROWS];
  int            row_idle    [NUM_ROWS];
  // expected values per row
  rq_pkg::preg_t exp_psrc1   [NUM_ROWS];
  rq_pkg::preg_t exp_psrc2   [NUM_ROWS];
  rq_pkg::preg_t exp_pdst    [NUM_ROWS];
  rq_pkg::preg_t exp_free    [NUM_ROWS];
  logic          exp_dst_vld [NUM_ROWS];
  rq_pkg::lreg_t exp_ldst    [NUM_ROWS];
  // row that last wrote each source, -1 for the reset map
  int            producer1   [NUM_ROWS];
  int            producer2   [NUM_ROWS];
  int            row_of_op   [256];

  // reference rename state
  rq_pkg::preg_t spec_map    [rq_pkg::NUM_LREG];
  int            last_writer [rq_pkg::NUM_LREG];
  rq_pkg::preg_t alloc_q     [$];

  // scoreboard
  logic        row_issued  [NUM_ROWS];
  int          issue_cycle [NUM_ROWS];
  int          acks_seen    = 0;
  int          retires_seen = 0;
  int          error_count  = 0;
  int          cycle_cnt    = 0;
  logic        ack_prev     = 1'b0;
  int unsigned lcg_state;

  tb_clock #(
    .RESET_CYCLES(RESET_CYCLES)
  ) tb_clock_inst (
    .clk_o(clk),
    .rst_n_o(rst_n)
  );

  rename_issue_top rename_issue_top_inst (
    .clk(clk), .rst_n(rst_n),
    .disp_req_i(disp_req), .disp_inst_i(disp_inst), .disp_ack_o(disp_ack),
    .iss_valid_o(iss_valid), .iss_op_o(iss_op),
    .iss_psrc1_o(iss_psrc1), .iss_psrc2_o(iss_psrc2), .iss_pdst_o(iss_pdst),
    .retire_valid_o(retire_valid), .ret_ldst_o(ret_ldst), .ret_pdst_o(ret_pdst),
    .ret_free_vld_o(ret_free_vld), .ret_free_preg_o(ret_free_preg)
  );

  //////////////////////////////////////////////////
  // failure reporting
  //////////////////////////////////////////////////
  task automatic stop_run();
    $display("Finished with errors");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic abort_run(input string msg);
    error_count++;
    $display("error at %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic check_eq(input string name, input int unsigned got, input int unsigned exp);
    if (got != exp)
    begin
      error_count++;
      $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      stop_run();
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus table and reference model
  //////////////////////////////////////////////////
  function automatic int unsigned lcg_step(input int unsigned s);
    lcg_step = s * 32'd1103515245 + 32'd12345;
  endfunction

  // renames the rows in program order, registers come 16..63 then freed ones
  task automatic build_table();
    int unsigned   r;
    logic          s1v;
    logic          s2v;
    logic          dv;
    rq_pkg::lreg_t s1;
    rq_pkg::lreg_t s2;
    rq_pkg::lreg_t d;
    for (int k = 0; k < 256; k++)
    begin
      row_of_op[k] = -1;
    end
    for (int i = 0; i < rq_pkg::NUM_LREG; i++)
    begin
      spec_map[i]    = rq_pkg::preg_t'(i);
      last_writer[i] = -1;
    end
    for (int p = rq_pkg::FIRST_FREE_PREG; p < rq_pkg::NUM_PREG; p++)
    begin
      alloc_q.push_back(rq_pkg::preg_t'(p));
    end
    lcg_state = 32'd71835;
    for (int n = 0; n < NUM_ROWS; n++)
    begin
      lcg_state = lcg_step(lcg_state);
      r  = lcg_state >> 8;
      s1 = r[3:0];
      s2 = r[7:4];
      d  = r[11:8];
      // each field present seven times in eight
      s1v = (r[14:12] != 3'd0);
      s2v = (r[17:15] != 3'd0);
      dv  = (r[20:18] != 3'd0);
      row_idle[n] = int'(r[22:21]);
      row_inst[n] = '0;
      row_inst[n][rq_pkg::BIT_LSRC1_VLD]               = s1v;
      row_inst[n][rq_pkg::LSRC1_LSB +: rq_pkg::LREG_W] = s1;
      row_inst[n][rq_pkg::BIT_LSRC2_VLD]               = s2v;
      row_inst[n][rq_pkg::LSRC2_LSB +: rq_pkg::LREG_W] = s2;
      row_inst[n][rq_pkg::BIT_LDST_VLD]                = dv;
      row_inst[n][rq_pkg::LDST_LSB +: rq_pkg::LREG_W]  = d;
      // odd stride keeps opcodes unique
      row_inst[n][rq_pkg::OP_LSB +: rq_pkg::OP_W]      = 8'(n * 37 + 11);
      row_of_op[8'(n * 37 + 11)] = n;
      // absent source reads as p0
      exp_psrc1[n]   = s1v ? spec_map[s1] : '0;
      exp_psrc2[n]   = s2v ? spec_map[s2] : '0;
      producer1[n]   = s1v ? last_writer[s1] : -1;
      producer2[n]   = s2v ? last_writer[s2] : -1;
      exp_pdst[n]    = alloc_q.pop_front();
      exp_free[n]    = spec_map[d];
      exp_dst_vld[n] = dv;
      exp_ldst[n]    = d;
      if (dv)
      begin
        alloc_q.push_back(spec_map[d]);
        spec_map[d]    = exp_pdst[n];
        last_writer[d] = n;
      end
      row_issued[n]  = 1'b0;
      issue_cycle[n] = 0;
    end
  endtask

  //////////////////////////////////////////////////
  // dispatch driver
  //////////////////////////////////////////////////
  task automatic dispatch_row(input int n);
    repeat (row_idle[n]) @(posedge clk);
    // request with a steady instruction
    @(posedge clk);
    disp_req  <= 1'b1;
    disp_inst <= row_inst[n];
    // ack may be held off by a full queue
    @(negedge clk);
    while (!disp_ack)
    begin
      @(negedge clk);
    end
    @(posedge clk);
    disp_req <= 1'b0;
    // ack holds until the low request is seen
    @(negedge clk);
    check_eq("disp_ack_o", 32'(disp_ack), 1);
    check_eq("ack count", acks_seen, n + 1);
    @(negedge clk);
    check_eq("disp_ack_o", 32'(disp_ack), 0);
  endtask

  //////////////////////////////////////////////////
  // issue and retire checks
  //////////////////////////////////////////////////
  // producer must have issued and run its full latency
  task automatic check_producer(input int p);
    if (p >= 0)
    begin
      if (!row_issued[p])
      begin
        abort_run("an instruction issued ahead of an instruction it depends on");
      end
      else if (cycle_cnt - issue_cycle[p] <= rq_pkg::EXEC_LAT)
      begin
        abort_run("an instruction issued before its producer completed");
      end
    end
  endtask

  task automatic check_issue();
    int n;
    n = row_of_op[iss_op];
    if (n < 0 || n >= acks_seen)
    begin
      abort_run("an instruction issued that was never dispatched");
    end
    else if (row_issued[n])
    begin
      abort_run("an instruction issued a second time");
    end
    else
    begin
      check_eq("iss_psrc1_o", 32'(iss_psrc1), 32'(exp_psrc1[n]));
      check_eq("iss_psrc2_o", 32'(iss_psrc2), 32'(exp_psrc2[n]));
      check_eq("iss_pdst_o", 32'(iss_pdst), 32'(exp_pdst[n]));
      check_producer(producer1[n]);
      check_producer(producer2[n]);
      row_issued[n]  = 1'b1;
      issue_cycle[n] = cycle_cnt;
    end
  endtask

  // retires follow program order
  task automatic check_retire();
    int n;
    n = retires_seen;
    if (n >= NUM_ROWS)
    begin
      abort_run("a retire came with no instruction left to retire");
    end
    else if (!row_issued[n])
    begin
      abort_run("an instruction retired without having issued");
    end
    else if (cycle_cnt - issue_cycle[n] <= rq_pkg::EXEC_LAT)
    begin
      abort_run("an instruction retired before it completed");
    end
    else
    begin
      check_eq("ret_ldst_o", 32'(ret_ldst), 32'(exp_ldst[n]));
      check_eq("ret_pdst_o", 32'(ret_pdst), 32'(exp_pdst[n]));
      check_eq("ret_free_vld_o", 32'(ret_free_vld), 32'(exp_dst_vld[n]));
      // no destination frees nothing
      if (exp_dst_vld[n])
      begin
        check_eq("ret_free_preg_o", 32'(ret_free_preg), 32'(exp_free[n]));
      end
      retires_seen++;
    end
  endtask

  // outputs are settled at the falling edge
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (disp_ack && !ack_prev)
      begin
        acks_seen++;
      end
      ack_prev = disp_ack;
      if (iss_valid)
      begin
        check_issue();
      end
      if (retire_valid)
      begin
        check_retire();
      end
    end
  end

  // cycle limit
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      abort_run("timeout, the run did not finish within the cycle limit");
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial
  begin
    disp_req  = 1'b0;
    disp_inst = '0;
    build_table();
    @(posedge rst_n);
    for (int n = 0; n < NUM_ROWS; n++)
    begin
      dispatch_row(n);
    end
    // drain, bounded by the cycle limit
    while (retires_seen < NUM_ROWS)
    begin
      @(posedge clk);
    end
    // quiet period so a stray issue or retire reaches the monitor
    repeat (rq_pkg::EXEC_LAT + 2) @(posedge clk);
    check_eq("ack count", acks_seen, NUM_ROWS);
    if (error_count == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
// clock and reset source for the testbench
// 20 ns period, reset held low for a set number of cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD = 10;

  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

  // release on a rising edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire
